// ==== common/book_pkg.sv ====
/*
  Shared sizes, command codes and packed structs for the order-book
  update pipeline
*/
`default_nettype none

package book_pkg;

  // Products held in the state table
  localparam int PRODUCTS_N = 16;
  localparam int PROD_ID_W  = $clog2(PRODUCTS_N);

  // Price levels per product
  localparam int ENTRIES_N  = 4;
  // Must hold 0..ENTRIES_N
  localparam int LISTSIZE_W = $clog2(ENTRIES_N + 1);

  // Level fields
  localparam int KEY_W      = 8;
  localparam int VOLUME_W   = 12;

  typedef logic [PROD_ID_W-1:0]  prod_id_t;
  typedef logic [KEY_W-1:0]      key_t;
  typedef logic [VOLUME_W-1:0]   volume_t;
  typedef logic [LISTSIZE_W-1:0] listsize_t;

  // Update opcodes
  typedef enum logic [1:0] {
    CMD_NOP    = 2'd0,
    CMD_ADD    = 2'd1,
    CMD_REMOVE = 2'd2
  } cmd_t;

  // One update command, 26 bits
  typedef struct packed {
    prod_id_t prod_id;
    cmd_t     cmd;
    key_t     key;
    volume_t  size;
  } upd_t;

  // One price level, 21 bits
  typedef struct packed {
    logic    vld;
    key_t    key;
    volume_t volume;
  } entry_t;

  // Whole list of one product, 87 bits
  typedef struct packed {
    entry_t [ENTRIES_N-1:0] entries;
    listsize_t              listsize;
  } state_t;

  // Level-0 report, 24 bits
  typedef struct packed {
    prod_id_t prod_id;
    key_t     key;
    volume_t  volume;
  } notify_t;

endpackage

`default_nettype wire

// ==== src/book_state_table.sv ====
/*
  Per-product state memory with one registered read port and one write port
*/
`timescale 1ns/1ns
`default_nettype none

module book_state_table (
    input  wire                       clk
  , input  wire                       rst
  // Read port
  , input  wire                       i_ren
  , input  wire book_pkg::prod_id_t   i_raddr
  , output book_pkg::state_t          o_rdata
  // Write port
  , input  wire                       i_wen
  , input  wire book_pkg::prod_id_t   i_waddr
  , input  wire book_pkg::state_t     i_wdata
);

  // List storage per product
  book_pkg::state_t                   mem [book_pkg::PRODUCTS_N];
  // Set on first write to a product
  logic [book_pkg::PRODUCTS_N-1:0]    prod_vld;

  always_ff @(posedge clk) begin
    if (i_wen) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_vld <= '0;
    end else if (i_wen) begin
      prod_vld[i_waddr] <= 1'b1;
    end
  end

  // Registered read with never-written product reading as empty list
  always_ff @(posedge clk) begin
    if (i_ren) begin
      o_rdata <= prod_vld[i_raddr] ? mem[i_raddr] : '0;
    end
  end

  // Enabled ports address a defined product
  a_addr_range : assert property (@(posedge clk) disable iff (rst)
    !(i_ren && $isunknown(i_raddr)) &&
    !(i_wen && $isunknown(i_waddr)));

endmodule

`default_nettype wire

// ==== update_pipe/update_front.sv ====
/*
  Update pipeline stages S1 and S2 with table read issue, write-back
  collision detection and state forwarding into the S3 register
*/
`timescale 1ns/1ns
`default_nettype none

module update_front (
    input  wire                       clk
  , input  wire                       rst
  // Update command
  , input  wire                       i_upd_vld
  , input  wire book_pkg::upd_t       i_upd
  // Table read data one cycle after ren
  , input  wire book_pkg::state_t     i_state_rdata
  // Registered write-back from exe
  , input  wire                       i_wrbk_vld
  , input  wire book_pkg::prod_id_t   i_wrbk_id
  , input  wire book_pkg::state_t     i_wrbk_state
  // Table read request
  , output logic                      o_state_ren
  , output book_pkg::prod_id_t        o_state_raddr
  // S3 register
  , output logic                      o_s3_vld
  , output book_pkg::upd_t            o_s3_upd
  , output book_pkg::state_t          o_s3_state
);

  // S1
  logic                               s1_vld_r;
  book_pkg::upd_t                     s1_upd_r;
  logic                               s1_coll;

  // S2
  logic                               s2_vld_r;
  book_pkg::upd_t                     s2_upd_r;
  logic                               s2_coll_r;
  book_pkg::state_t                   s2_coll_state_r;
  logic                               s2_fwd_cur;
  book_pkg::state_t                   s2_state;

  // Write-back lands this cycle on the S1 product
  assign s1_coll = s1_vld_r & i_wrbk_vld & (i_wrbk_id == s1_upd_r.prod_id);

  // Read killed on collision and state taken from write-back
  assign o_state_ren   = s1_vld_r & ~s1_coll;
  assign o_state_raddr = s1_upd_r.prod_id;

  // Current write-back hits S2 product
  assign s2_fwd_cur = i_wrbk_vld & (i_wrbk_id == s2_upd_r.prod_id);

  // Newest state first
  always_comb begin
    if (s2_fwd_cur) begin
      s2_state = i_wrbk_state;
    end else if (s2_coll_r) begin
      s2_state = s2_coll_state_r;
    end else begin
      s2_state = i_state_rdata;
    end
  end

  // Stage valids
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld_r <= 1'b0;
      s2_vld_r <= 1'b0;
      o_s3_vld <= 1'b0;
    end else begin
      s1_vld_r <= i_upd_vld;
      s2_vld_r <= s1_vld_r;
      o_s3_vld <= s2_vld_r;
    end
  end

  // Stage payloads
  always_ff @(posedge clk) begin
    if (i_upd_vld) begin
      s1_upd_r <= i_upd;
    end
    if (s1_vld_r) begin
      s2_upd_r        <= s1_upd_r;
      s2_coll_r       <= s1_coll;
      s2_coll_state_r <= i_wrbk_state;
    end
    if (s2_vld_r) begin
      o_s3_upd   <= s2_upd_r;
      o_s3_state <= s2_state;
    end
  end

  // Table data taken by S2 is defined
  a_rdata_known : assert property (@(posedge clk) disable iff (rst)
    (s2_vld_r && !s2_fwd_cur && !s2_coll_r) |-> !$isunknown(i_state_rdata));

endmodule

`default_nettype wire

// ==== update_pipe/update_exe.sv ====
/*
  Update pipeline stage S3 with list execution, level-0 change detection,
  write-back and notify registers
*/
`timescale 1ns/1ns
`default_nettype none

module update_exe (
    input  wire                       clk
  , input  wire                       rst
  // S3 command and resolved state
  , input  wire                       i_s3_vld
  , input  wire book_pkg::upd_t       i_s3_upd
  , input  wire book_pkg::state_t     i_s3_state
  // Write-back to table and front
  , output logic                      o_wrbk_vld
  , output book_pkg::prod_id_t        o_wrbk_id
  , output book_pkg::state_t          o_wrbk_state
  // Notify bus
  , output logic                      o_lv0_vld
  , output book_pkg::notify_t         o_lv0
);

  logic                               bypass;
  book_pkg::state_t                   st_cur;
  book_pkg::state_t                   st_nxt;
  logic [book_pkg::ENTRIES_N-1:0]     hit_oh;
  logic [book_pkg::ENTRIES_N-1:0]     free_oh;
  logic                               hit_any;
  book_pkg::entry_t                   lv0_cur;
  book_pkg::entry_t                   lv0_nxt;
  logic                               lv0_chg;

  // Volume add clamping at all ones
  function automatic book_pkg::volume_t sat_add(input book_pkg::volume_t a,
                                                input book_pkg::volume_t b);
    logic [book_pkg::VOLUME_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[book_pkg::VOLUME_W] ? '1 : sum[book_pkg::VOLUME_W-1:0];
  endfunction

  function automatic book_pkg::listsize_t count_vld(input book_pkg::state_t st);
    book_pkg::listsize_t n;
    n = '0;
    for (int i = 0; i < book_pkg::ENTRIES_N; i++) begin
      n = n + book_pkg::listsize_t'(st.entries[i].vld);
    end
    return n;
  endfunction

  // Smallest valid key; all zero when list is empty
  function automatic book_pkg::entry_t level0(input book_pkg::state_t st);
    book_pkg::entry_t best;
    best = '0;
    for (int i = 0; i < book_pkg::ENTRIES_N; i++) begin
      if (st.entries[i].vld && (!best.vld || (st.entries[i].key < best.key))) begin
        best = st.entries[i];
      end
    end
    return best;
  endfunction

  // Previous command on same product still in the write-back register
  assign bypass = o_wrbk_vld & (o_wrbk_id == i_s3_upd.prod_id);
  assign st_cur = bypass ? o_wrbk_state : i_s3_state;

  // One-hot key match and lowest free slot
  always_comb begin
    logic taken;
    taken = 1'b0;
    for (int i = 0; i < book_pkg::ENTRIES_N; i++) begin
      hit_oh[i]  = st_cur.entries[i].vld && (st_cur.entries[i].key == i_s3_upd.key);
      free_oh[i] = !st_cur.entries[i].vld && !taken;
      taken      = taken | !st_cur.entries[i].vld;
    end
  end

  assign hit_any = |hit_oh;

  // Apply command per entry
  always_comb begin
    st_nxt = st_cur;
    for (int i = 0; i < book_pkg::ENTRIES_N; i++) begin
      case (i_s3_upd.cmd)
        book_pkg::CMD_ADD: begin
          if (hit_oh[i]) begin
            st_nxt.entries[i].volume = sat_add(st_cur.entries[i].volume, i_s3_upd.size);
          end else if (!hit_any && free_oh[i]) begin
            st_nxt.entries[i].vld    = 1'b1;
            st_nxt.entries[i].key    = i_s3_upd.key;
            st_nxt.entries[i].volume = i_s3_upd.size;
          end
        end
        book_pkg::CMD_REMOVE: begin
          // Entry freed when nothing is left
          if (hit_oh[i]) begin
            if (i_s3_upd.size >= st_cur.entries[i].volume) begin
              st_nxt.entries[i] = '0;
            end else begin
              st_nxt.entries[i].volume = st_cur.entries[i].volume - i_s3_upd.size;
            end
          end
        end
        default: begin
        end
      endcase
    end
    st_nxt.listsize = count_vld(st_nxt);
  end

  assign lv0_cur = level0(st_cur);
  assign lv0_nxt = level0(st_nxt);
  assign lv0_chg = (lv0_cur.key != lv0_nxt.key) || (lv0_cur.volume != lv0_nxt.volume);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wrbk_vld <= 1'b0;
      o_lv0_vld  <= 1'b0;
    end else begin
      o_wrbk_vld <= i_s3_vld;
      o_lv0_vld  <= i_s3_vld & lv0_chg;
    end
  end

  always_ff @(posedge clk) begin
    if (i_s3_vld) begin
      o_wrbk_id    <= i_s3_upd.prod_id;
      o_wrbk_state <= st_nxt;
    end
    if (i_s3_vld && lv0_chg) begin
      o_lv0.prod_id <= i_s3_upd.prod_id;
      o_lv0.key     <= lv0_nxt.key;
      o_lv0.volume  <= lv0_nxt.volume;
    end
  end

  // Incoming list stays within bounds
  a_listsize_max : assert property (@(posedge clk) disable iff (rst)
    i_s3_vld |-> (i_s3_state.listsize <= book_pkg::ENTRIES_N));

  // State from table or forwarding keeps listsize consistent
  a_listsize_cnt : assert property (@(posedge clk) disable iff (rst)
    i_s3_vld |-> (i_s3_state.listsize == count_vld(i_s3_state)));

endmodule

`default_nettype wire

// ==== src/book_update_top.sv ====
/*
  Order-book update top: front stages, execute stage and state table
*/
`timescale 1ns/1ns
`default_nettype none

module book_update_top (
    input  wire                       clk
  , input  wire                       rst
  // Update command strobe
  , input  wire                       i_upd_vld
  , input  wire book_pkg::upd_t       i_upd
  // Level-0 notify
  , output logic                      o_lv0_vld
  , output book_pkg::notify_t         o_lv0
);

  // Table read
  logic                               state_ren;
  book_pkg::prod_id_t                 state_raddr;
  book_pkg::state_t                   state_rdata;

  // Front to exe
  logic                               s3_vld;
  book_pkg::upd_t                     s3_upd;
  book_pkg::state_t                   s3_state;

  // Write-back, shared by table and front
  logic                               wrbk_vld;
  book_pkg::prod_id_t                 wrbk_id;
  book_pkg::state_t                   wrbk_state;

  update_front u_front (
      .clk            (clk)
    , .rst            (rst)
    , .i_upd_vld      (i_upd_vld)
    , .i_upd          (i_upd)
    , .i_state_rdata  (state_rdata)
    , .i_wrbk_vld     (wrbk_vld)
    , .i_wrbk_id      (wrbk_id)
    , .i_wrbk_state   (wrbk_state)
    , .o_state_ren    (state_ren)
    , .o_state_raddr  (state_raddr)
    , .o_s3_vld       (s3_vld)
    , .o_s3_upd       (s3_upd)
    , .o_s3_state     (s3_state)
  );

  update_exe u_exe (
      .clk            (clk)
    , .rst            (rst)
    , .i_s3_vld       (s3_vld)
    , .i_s3_upd       (s3_upd)
    , .i_s3_state     (s3_state)
    , .o_wrbk_vld     (wrbk_vld)
    , .o_wrbk_id      (wrbk_id)
    , .o_wrbk_state   (wrbk_state)
    , .o_lv0_vld      (o_lv0_vld)
    , .o_lv0          (o_lv0)
  );

  book_state_table u_table (
      .clk            (clk)
    , .rst            (rst)
    , .i_ren          (state_ren)
    , .i_raddr        (state_raddr)
    , .o_rdata        (state_rdata)
    , .i_wen          (wrbk_vld)
    , .i_waddr        (wrbk_id)
    , .i_wdata        (wrbk_state)
  );

endmodule

`default_nettype wire

// ==== tests/tb_book_update.sv ====
/*
  Testbench for the order-book update pipeline: stimulus table with
  expected level-0 notifies, checked at the fixed 4-cycle latency
*/
`timescale 1ns/1ns
`default_nettype none

module tb_book_update;

  // Pipeline latency from input edge to registered notify
  localparam int LATENCY   = 4;
  localparam int DRAIN_MAX = 32;

  // One table row: stimulus then expected notify
  typedef struct packed {
    logic               vld;
    book_pkg::upd_t     upd;
    logic               exp_vld;
    book_pkg::notify_t  exp;
  } row_t;

  logic               clk;
  logic               rst;
  logic               i_upd_vld;
  book_pkg::upd_t     i_upd;
  logic               o_lv0_vld;
  book_pkg::notify_t  o_lv0;

  row_t               rows[$];
  // Row indices applied and not yet checked, oldest first
  int                 pending[$];
  int                 drain_cnt;

  book_update_top UUT (
      .clk        (clk)
    , .rst        (rst)
    , .i_upd_vld  (i_upd_vld)
    , .i_upd      (i_upd)
    , .o_lv0_vld  (o_lv0_vld)
    , .o_lv0      (o_lv0)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic add_row(input logic vld, input book_pkg::prod_id_t prod,
                         input book_pkg::cmd_t cmd, input book_pkg::key_t key,
                         input book_pkg::volume_t size, input logic exp_vld,
                         input book_pkg::key_t exp_key, input book_pkg::volume_t exp_vol);
    row_t r;
    r.vld         = vld;
    r.upd.prod_id = prod;
    r.upd.cmd     = cmd;
    r.upd.key     = key;
    r.upd.size    = size;
    r.exp_vld     = exp_vld;
    r.exp.prod_id = prod;
    r.exp.key     = exp_key;
    r.exp.volume  = exp_vol;
    rows.push_back(r);
  endtask

  // Cycle without a command
  task automatic add_idle();
    add_row(1'b0, 4'd0, book_pkg::CMD_NOP, 8'h00, 12'd0, 1'b0, 8'h00, 12'd0);
  endtask

  task automatic load_table();
    // Fresh product, insert then larger key
    add_row(1'b1, 4'd1, book_pkg::CMD_ADD,    8'h20, 12'd100, 1'b1, 8'h20, 12'd100);
    add_row(1'b1, 4'd1, book_pkg::CMD_ADD,    8'h30, 12'd50,  1'b0, 8'h00, 12'd0);
    // Level-0 volume up, then partly down
    add_row(1'b1, 4'd1, book_pkg::CMD_ADD,    8'h20, 12'd25,  1'b1, 8'h20, 12'd125);
    add_row(1'b1, 4'd1, book_pkg::CMD_REMOVE, 8'h20, 12'd40,  1'b1, 8'h20, 12'd85);
    // Level 0 freed, next key moves up, then list empties
    add_row(1'b1, 4'd1, book_pkg::CMD_REMOVE, 8'h20, 12'd85,  1'b1, 8'h30, 12'd50);
    add_row(1'b1, 4'd1, book_pkg::CMD_REMOVE, 8'h30, 12'd200, 1'b1, 8'h00, 12'd0);
    // Product 2 filled at gaps of 2, 3 and 4 cycles
    add_row(1'b1, 4'd2, book_pkg::CMD_ADD,    8'h50, 12'd10,  1'b1, 8'h50, 12'd10);
    add_idle();
    add_row(1'b1, 4'd2, book_pkg::CMD_ADD,    8'h60, 12'd20,  1'b0, 8'h00, 12'd0);
    add_idle();
    add_idle();
    add_row(1'b1, 4'd2, book_pkg::CMD_ADD,    8'h70, 12'd30,  1'b0, 8'h00, 12'd0);
    add_row(1'b1, 4'd3, book_pkg::CMD_ADD,    8'h10, 12'd5,   1'b1, 8'h10, 12'd5);
    add_idle();
    add_idle();
    add_row(1'b1, 4'd2, book_pkg::CMD_ADD,    8'h80, 12'd40,  1'b0, 8'h00, 12'd0);
    // Full list, smaller key dropped
    add_row(1'b1, 4'd2, book_pkg::CMD_ADD,    8'h40, 12'd99,  1'b0, 8'h00, 12'd0);
    add_idle();
    add_row(1'b1, 4'd2, book_pkg::CMD_REMOVE, 8'h50, 12'd10,  1'b1, 8'h60, 12'd20);
    // Product 4 back to back, gaps of 1 and 2
    add_row(1'b1, 4'd4, book_pkg::CMD_ADD,    8'h08, 12'h100, 1'b1, 8'h08, 12'h100);
    add_row(1'b1, 4'd4, book_pkg::CMD_ADD,    8'h08, 12'h010, 1'b1, 8'h08, 12'h110);
    add_row(1'b1, 4'd2, book_pkg::CMD_REMOVE, 8'h60, 12'd5,   1'b1, 8'h60, 12'd15);
    add_row(1'b1, 4'd4, book_pkg::CMD_ADD,    8'h04, 12'd7,   1'b1, 8'h04, 12'd7);
    add_row(1'b1, 4'd4, book_pkg::CMD_REMOVE, 8'h04, 12'd3,   1'b1, 8'h04, 12'd4);
    add_row(1'b1, 4'd4, book_pkg::CMD_NOP,    8'h04, 12'd0,   1'b0, 8'h00, 12'd0);
    add_row(1'b1, 4'd4, book_pkg::CMD_REMOVE, 8'h04, 12'd4,   1'b1, 8'h08, 12'h110);
    // Saturating add
    add_row(1'b1, 4'd4, book_pkg::CMD_ADD,    8'h08, 12'hFFF, 1'b1, 8'h08, 12'hFFF);
    // Interleaved products, NOP and absent keys
    add_row(1'b1, 4'd3, book_pkg::CMD_NOP,    8'h10, 12'd5,   1'b0, 8'h00, 12'd0);
    add_row(1'b1, 4'd5, book_pkg::CMD_ADD,    8'h90, 12'd1,   1'b1, 8'h90, 12'd1);
    add_row(1'b1, 4'd3, book_pkg::CMD_REMOVE, 8'h10, 12'd1,   1'b1, 8'h10, 12'd4);
    add_row(1'b1, 4'd5, book_pkg::CMD_REMOVE, 8'h91, 12'd1,   1'b0, 8'h00, 12'd0);
    add_row(1'b1, 4'd1, book_pkg::CMD_REMOVE, 8'h30, 12'd1,   1'b0, 8'h00, 12'd0);
    add_row(1'b1, 4'd1, book_pkg::CMD_ADD,    8'h33, 12'd2,   1'b1, 8'h33, 12'd2);
  endtask

  task automatic check_strobe(input logic got, input logic exp, input int row);
    if (got !== exp) begin
      $display("** Error at %0t: row %0d notify strobe %b, expected %b",
               $time, row, got, exp);
      $display("TEST FAIL");
      $fatal(1, "notify strobe mismatch");
    end
  endtask

  task automatic check_notify(input book_pkg::notify_t got, input book_pkg::notify_t exp,
                              input int row);
    if (got !== exp) begin
      $display("** Error at %0t: row %0d notify prod %0d key %h vol %h, expected %0d %h %h",
               $time, row, got.prod_id, got.key, got.volume,
               exp.prod_id, exp.key, exp.volume);
      $display("TEST FAIL");
      $fatal(1, "notify payload mismatch");
    end
  endtask

  // Oldest applied row is due on the notify bus now
  task automatic check_oldest();
    int idx;
    idx = pending.pop_front();
    check_strobe(o_lv0_vld, rows[idx].exp_vld, idx);
    if (rows[idx].exp_vld) begin
      check_notify(o_lv0, rows[idx].exp, idx);
    end
  endtask

  initial begin
    rst       = 1'b1;
    i_upd_vld = 1'b0;
    i_upd     = '0;
    drain_cnt = 0;
    load_table();

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Apply rows, outputs sampled mid-cycle
    for (int r = 0; r < rows.size(); r++) begin
      @(posedge clk);
      i_upd_vld <= rows[r].vld;
      i_upd     <= rows[r].upd;
      pending.push_back(r);
      @(negedge clk);
      if (pending.size() > LATENCY) begin
        check_oldest();
      end
    end

    // Drain last rows with idle inputs
    while ((pending.size() > 0) && (drain_cnt < DRAIN_MAX)) begin
      @(posedge clk);
      i_upd_vld <= 1'b0;
      i_upd     <= '0;
      @(negedge clk);
      check_oldest();
      drain_cnt++;
    end

    if (pending.size() != 0) begin
      $display("Timeout while draining the pipeline, %0d rows unchecked", pending.size());
      $display("TEST FAIL");
      $fatal(1, "drain timeout");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/book_pkg.sv
src/book_state_table.sv
update_pipe/update_front.sv
update_pipe/update_exe.sv
src/book_update_top.sv
tests/tb_book_update.sv

// ==== Bender.yml ====
package:
  name: book_update

sources:
  - common/book_pkg.sv
  - src/book_state_table.sv
  - update_pipe/update_front.sv
  - update_pipe/update_exe.sv
  - src/book_update_top.sv
  - target: test
    files:
      - tests/tb_book_update.sv

dependencies: {}
